// ==== gmii_tx_pkg.sv ====
// types, enums and framing constants shared by the gmii transmit framer and its testbench
package gmii_tx_pkg;

	typedef logic [7:0]  byte_t;	// one gmii byte
	typedef logic [63:0] qword_t;	// upstream word, frame byte 0 in bits 7..0
	typedef logic [15:0] len_t;		// payload length in bytes
	typedef logic [31:0] stat_t;
	typedef logic [31:0] crc_t;

	// fmac_speed code, 2'b00 falls back to 1G
	typedef enum logic [1:0] {SPEED_1G = 2'b01, SPEED_100M = 2'b10, SPEED_10M = 2'b11} speed_t;

	typedef enum logic [2:0] {IDLE, PREAMBLE, SFD, DATA, FCS, GAP} tx_state_t;

	// where the next gmii byte comes from
	typedef enum logic [2:0] {SRC_IDLE, SRC_PRE, SRC_SFD, SRC_DATA, SRC_FCS} tx_src_t;

	localparam byte_t PREAMBLE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE      = 8'hD5;

	localparam len_t PREAMBLE_LEN = 16'd7;
	localparam len_t FCS_LEN      = 16'd4;
	localparam len_t GAP_LEN      = 16'd12;	// inter-frame gap in byte times

	// ethernet crc-32, lsb first
	localparam crc_t CRC_POLY    = 32'hEDB88320;
	localparam crc_t CRC_INIT    = 32'hFFFFFFFF;
	localparam crc_t CRC_XOR_OUT = 32'hFFFFFFFF;

	// clk125 cycles per byte at the slow speeds
	localparam int unsigned DIV_100M = 10;
	localparam int unsigned DIV_10M  = 100;

endpackage

// ==== byte_strobe_timer.sv ====
// free-running byte strobe for the selected gmii speed, one tick per byte time
`timescale 1ns/100ps

module byte_strobe_timer
(
	input  logic                clk125,
	input  logic                rst_,
	input  gmii_tx_pkg::speed_t speed,
	output logic                byte_tick
);

	logic [6:0] div_cnt;
	logic [6:0] reload;
	gmii_tx_pkg::speed_t speed_q;	// last speed, to spot a change

	always_comb
	begin
		case (speed)
			gmii_tx_pkg::SPEED_100M: reload = 7'(gmii_tx_pkg::DIV_100M - 1);
			gmii_tx_pkg::SPEED_10M:  reload = 7'(gmii_tx_pkg::DIV_10M - 1);
			default:                 reload = 7'd0;	// 1G and code 00
		endcase
	end

	// reload stays 0 at 1G so the strobe is high every cycle
	assign byte_tick = (reload == 7'd0) || (div_cnt == 7'd0);

	always_ff @(posedge clk125)
	begin
		if (!rst_)
		begin
			div_cnt <= 7'd0;
			speed_q <= gmii_tx_pkg::SPEED_1G;
		end
		else
		begin
			speed_q <= speed;
			if ((speed != speed_q) || (div_cnt == 7'd0))
				div_cnt <= reload;	// restart at once on a speed change
			else
				div_cnt <= div_cnt - 7'd1;
		end
	end

endmodule

// ==== gmii_tx_fsm.sv ====
// frame sequencer, accepts a packet on rts/cts and steps it through preamble, sfd, data, fcs, gap
`timescale 1ns/100ps

module gmii_tx_fsm
(
	input  logic                  clk125,
	input  logic                  rst_,
	input  logic                  byte_tick,
	input  logic                  linkup,
	input  logic                  rts,
	input  gmii_tx_pkg::len_t     rbytes,
	output logic                  cts,
	output logic                  word_take,
	output gmii_tx_pkg::tx_src_t  byte_src,
	output logic                  frame_done,
	output gmii_tx_pkg::len_t     frame_len
);

	gmii_tx_pkg::tx_state_t state;
	gmii_tx_pkg::len_t      cnt;	// bytes done in the current phase
	logic accept;
	logic last_data;

	assign accept    = rts & cts;
	assign last_data = (cnt == frame_len - 16'd1);

	// first word at acceptance, then one per eight payload bytes
	assign word_take = accept ||
		(byte_tick && (state == gmii_tx_pkg::DATA) && (cnt[2:0] == 3'd7) && !last_data);

	always_ff @(posedge clk125)
	begin
		if (accept)
			frame_len <= rbytes;
	end

	always_ff @(posedge clk125)
	begin
		if (!rst_)
		begin
			state      <= gmii_tx_pkg::IDLE;
			byte_src   <= gmii_tx_pkg::SRC_IDLE;
			cnt        <= '0;
			cts        <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			frame_done <= 1'b0;
			cts        <= linkup && (state == gmii_tx_pkg::IDLE) && !accept;
			if (accept)
			begin
				state    <= gmii_tx_pkg::PREAMBLE;
				byte_src <= gmii_tx_pkg::SRC_PRE;
				cnt      <= '0;
			end
			else if (byte_tick)
			begin
				cnt <= cnt + 16'd1;	// phase ends below override this
				case (state)
					gmii_tx_pkg::PREAMBLE:
						if (cnt == gmii_tx_pkg::PREAMBLE_LEN - 16'd1)
						begin
							state    <= gmii_tx_pkg::SFD;
							byte_src <= gmii_tx_pkg::SRC_SFD;
							cnt      <= '0;
						end
					gmii_tx_pkg::SFD:
					begin
						state    <= gmii_tx_pkg::DATA;
						byte_src <= gmii_tx_pkg::SRC_DATA;
						cnt      <= '0;
					end
					gmii_tx_pkg::DATA:
						if (last_data)
						begin
							state    <= gmii_tx_pkg::FCS;
							byte_src <= gmii_tx_pkg::SRC_FCS;
							cnt      <= '0;
						end
					gmii_tx_pkg::FCS:
						if (cnt == gmii_tx_pkg::FCS_LEN - 16'd1)
						begin
							state      <= gmii_tx_pkg::GAP;
							byte_src   <= gmii_tx_pkg::SRC_IDLE;
							cnt        <= '0;
							frame_done <= 1'b1;	// last check byte goes out now
						end
					gmii_tx_pkg::GAP:
						if (cnt == gmii_tx_pkg::GAP_LEN - 16'd1)
						begin
							state <= gmii_tx_pkg::IDLE;
							cnt   <= '0;
						end
					default:
					begin
						state    <= gmii_tx_pkg::IDLE;
						byte_src <= gmii_tx_pkg::SRC_IDLE;
						cnt      <= '0;
					end
				endcase
			end
		end
	end

endmodule

// ==== tx_byte_path.sv ====
// payload word shifter and registered gmii output stage, one byte per byte tick
`timescale 1ns/100ps

module tx_byte_path
(
	input  logic                  clk125,
	input  logic                  rst_,
	input  logic                  byte_tick,
	input  gmii_tx_pkg::tx_src_t  byte_src,
	input  logic                  word_take,
	input  gmii_tx_pkg::qword_t   rdata,
	input  gmii_tx_pkg::byte_t    fcs_byte,
	output gmii_tx_pkg::byte_t    data_byte,
	output gmii_tx_pkg::byte_t    gmii_txd,
	output logic                  gmii_tx_en
);

	gmii_tx_pkg::qword_t shreg;	// current payload word, next byte lowest

	assign data_byte = shreg[7:0];

	// a new word replaces the one whose eighth byte goes out on the same edge
	always_ff @(posedge clk125)
	begin
		if (word_take)
			shreg <= rdata;
		else if (byte_tick && (byte_src == gmii_tx_pkg::SRC_DATA))
			shreg <= {8'h00, shreg[63:8]};
	end

	always_ff @(posedge clk125)
	begin
		if (!rst_)
		begin
			gmii_txd   <= 8'h00;
			gmii_tx_en <= 1'b0;
		end
		else if (byte_tick)
		begin
			gmii_tx_en <= (byte_src != gmii_tx_pkg::SRC_IDLE);
			case (byte_src)
				gmii_tx_pkg::SRC_PRE:  gmii_txd <= gmii_tx_pkg::PREAMBLE_BYTE;
				gmii_tx_pkg::SRC_SFD:  gmii_txd <= gmii_tx_pkg::SFD_BYTE;
				gmii_tx_pkg::SRC_DATA: gmii_txd <= data_byte;
				gmii_tx_pkg::SRC_FCS:  gmii_txd <= fcs_byte;
				default:               gmii_txd <= 8'h00;	// idle between frames
			endcase
		end
	end

endmodule

// ==== fcs_crc32.sv ====
// byte-wise ethernet crc-32 over the payload, shifts the check bytes out lowest first
`timescale 1ns/100ps

module fcs_crc32
(
	input  logic                  clk125,
	input  logic                  rst_,
	input  logic                  byte_tick,
	input  gmii_tx_pkg::tx_src_t  byte_src,
	input  gmii_tx_pkg::byte_t    data_byte,
	output gmii_tx_pkg::byte_t    fcs_byte
);

	gmii_tx_pkg::crc_t crc;

	// one byte through the reflected polynomial, lsb first
	function automatic gmii_tx_pkg::crc_t crc_byte(gmii_tx_pkg::crc_t c, gmii_tx_pkg::byte_t d);
		gmii_tx_pkg::crc_t r;
		r = c ^ {24'd0, d};
		for (int i = 0; i < 8; i++)
		begin
			if (r[0])
				r = (r >> 1) ^ gmii_tx_pkg::CRC_POLY;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	assign fcs_byte = crc[7:0] ^ gmii_tx_pkg::CRC_XOR_OUT[7:0];

	always_ff @(posedge clk125)
	begin
		if (!rst_)
			crc <= gmii_tx_pkg::CRC_INIT;
		else if (byte_tick)
		begin
			case (byte_src)
				gmii_tx_pkg::SRC_SFD:  crc <= gmii_tx_pkg::CRC_INIT;	// fresh frame
				gmii_tx_pkg::SRC_DATA: crc <= crc_byte(crc, data_byte);
				gmii_tx_pkg::SRC_FCS:  crc <= {8'hFF, crc[31:8]};	// next check byte down
				default:               crc <= crc;
			endcase
		end
	end

endmodule

// ==== tx_stat_counters.sv ====
// transmitted packet and payload byte counters, byte count clearable
`timescale 1ns/100ps

module tx_stat_counters
(
	input  logic                clk125,
	input  logic                rst_,
	input  logic                frame_done,
	input  gmii_tx_pkg::len_t   frame_len,
	input  logic                byte_cnt_clr,
	output gmii_tx_pkg::stat_t  tx_pkt_cnt,
	output gmii_tx_pkg::stat_t  tx_byte_cnt
);

	always_ff @(posedge clk125)
	begin
		if (!rst_)
		begin
			tx_pkt_cnt  <= '0;
			tx_byte_cnt <= '0;
		end
		else
		begin
			if (frame_done)
				tx_pkt_cnt <= tx_pkt_cnt + 32'd1;

			// clear beats a frame ending on the same edge
			if (byte_cnt_clr)
				tx_byte_cnt <= '0;
			else if (frame_done)
				tx_byte_cnt <= tx_byte_cnt + gmii_tx_pkg::stat_t'(frame_len);
		end
	end

endmodule

// ==== gmii_tx.sv ====
// top of the gmii transmit framer, connects timer, sequencer, byte path, crc and counters
`timescale 1ns/100ps

module gmii_tx
(
	input  logic                 clk125,
	input  logic                 rst_,
	input  gmii_tx_pkg::speed_t  fmac_speed,
	input  logic                 linkup,
	input  logic                 rts,
	input  gmii_tx_pkg::qword_t  rdata,
	input  gmii_tx_pkg::len_t    rbytes,
	input  logic                 tx_byte_cnt_clr,
	output logic                 cts,
	output logic                 word_take,
	output gmii_tx_pkg::byte_t   gmii_txd,
	output logic                 gmii_tx_en,
	output gmii_tx_pkg::stat_t   tx_pkt_cnt,
	output gmii_tx_pkg::stat_t   tx_byte_cnt
);

	logic                  byte_tick;
	gmii_tx_pkg::tx_src_t  byte_src;
	gmii_tx_pkg::byte_t    fcs_byte;
	gmii_tx_pkg::byte_t    data_byte;
	logic                  frame_done;
	gmii_tx_pkg::len_t     frame_len;

	byte_strobe_timer byte_strobe_timer_i (
		.clk125    (clk125),
		.rst_      (rst_),
		.speed     (fmac_speed),
		.byte_tick (byte_tick)
	);

	gmii_tx_fsm gmii_tx_fsm_i (
		.clk125     (clk125),
		.rst_       (rst_),
		.byte_tick  (byte_tick),
		.linkup     (linkup),
		.rts        (rts),
		.rbytes     (rbytes),
		.cts        (cts),
		.word_take  (word_take),
		.byte_src   (byte_src),
		.frame_done (frame_done),
		.frame_len  (frame_len)
	);

	tx_byte_path tx_byte_path_i (
		.clk125     (clk125),
		.rst_       (rst_),
		.byte_tick  (byte_tick),
		.byte_src   (byte_src),
		.word_take  (word_take),
		.rdata      (rdata),
		.fcs_byte   (fcs_byte),
		.data_byte  (data_byte),
		.gmii_txd   (gmii_txd),
		.gmii_tx_en (gmii_tx_en)
	);

	fcs_crc32 fcs_crc32_i (
		.clk125    (clk125),
		.rst_      (rst_),
		.byte_tick (byte_tick),
		.byte_src  (byte_src),
		.data_byte (data_byte),
		.fcs_byte  (fcs_byte)
	);

	tx_stat_counters tx_stat_counters_i (
		.clk125       (clk125),
		.rst_         (rst_),
		.frame_done   (frame_done),
		.frame_len    (frame_len),
		.byte_cnt_clr (tx_byte_cnt_clr),
		.tx_pkt_cnt   (tx_pkt_cnt),
		.tx_byte_cnt  (tx_byte_cnt)
	);

endmodule

// ==== tb_gmii_tx.sv ====
// self-checking testbench for the gmii transmit framer that runs a table of frames at all three speeds
`timescale 1ns/100ps

module tb_gmii_tx;

	localparam int NROWS = 11;

	logic                 clk125;
	logic                 rst_;
	gmii_tx_pkg::speed_t  fmac_speed;
	logic                 linkup;
	logic                 rts;
	gmii_tx_pkg::qword_t  rdata;
	gmii_tx_pkg::len_t    rbytes;
	logic                 tx_byte_cnt_clr;
	logic                 cts;
	logic                 word_take;
	gmii_tx_pkg::byte_t   gmii_txd;
	logic                 gmii_tx_en;
	gmii_tx_pkg::stat_t   tx_pkt_cnt;
	gmii_tx_pkg::stat_t   tx_byte_cnt;

	// one row per test with speed, payload length, linkup and a byte counter clear before the frame
	gmii_tx_pkg::speed_t row_speed [NROWS] = '{
		gmii_tx_pkg::SPEED_1G, gmii_tx_pkg::SPEED_1G, gmii_tx_pkg::SPEED_1G,
		gmii_tx_pkg::SPEED_1G, gmii_tx_pkg::SPEED_1G, gmii_tx_pkg::SPEED_100M,
		gmii_tx_pkg::SPEED_100M, gmii_tx_pkg::SPEED_10M, gmii_tx_pkg::SPEED_10M,
		gmii_tx_pkg::SPEED_100M, gmii_tx_pkg::SPEED_1G};
	gmii_tx_pkg::len_t row_len [NROWS] = '{16'd1, 16'd7, 16'd8, 16'd9, 16'd64, 16'd9, 16'd3,
		16'd9, 16'd3, 16'd20, 16'd16};
	bit row_link [NROWS] = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 1};
	bit row_clr [NROWS]  = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1};

	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	logic [31:0] rng = 32'h81e4_178c;
	gmii_tx_pkg::stat_t exp_pkts = '0;
	gmii_tx_pkg::stat_t exp_bytes = '0;

	gmii_tx gmii_tx_i (.*);

	initial
	begin
		clk125 = 1'b0;
		forever #50 clk125 = ~clk125;
	end

	function automatic logic [31:0] next_random();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic int byte_clocks(gmii_tx_pkg::speed_t sp);
		case (sp)
			gmii_tx_pkg::SPEED_100M: return gmii_tx_pkg::DIV_100M;
			gmii_tx_pkg::SPEED_10M:  return gmii_tx_pkg::DIV_10M;
			default:                 return 1;	// 1G and code 00
		endcase
	endfunction

	// reflected ethernet fcs computed bit by bit
	function automatic gmii_tx_pkg::crc_t payload_crc(input gmii_tx_pkg::byte_t pay[$]);
		gmii_tx_pkg::crc_t c;
		c = gmii_tx_pkg::CRC_INIT;
		foreach (pay[i])
			for (int b = 0; b < 8; b++)
				c = (c >> 1) ^ ((c[0] ^ pay[i][b]) ? gmii_tx_pkg::CRC_POLY : 32'h0);
		return c ^ gmii_tx_pkg::CRC_XOR_OUT;
	endfunction

	task automatic note_failure(input string what);
		errors++;
		$display("ERROR at %0d ns: %s", $time, what);
	endtask

	task automatic check_byte(input gmii_tx_pkg::byte_t got, input gmii_tx_pkg::byte_t exp,
		input string what);
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0d ns: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
		end
	endtask

	task automatic check_stat(input gmii_tx_pkg::stat_t got, input gmii_tx_pkg::stat_t exp,
		input string what);
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_len(input gmii_tx_pkg::len_t got, input gmii_tx_pkg::len_t exp,
		input string what);
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests++;
		if (errors == err_start)
			$display("test %0d %s: ok", tests, name);
		else
		begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - err_start);
		end
	endtask

	task automatic send_frame(input int r);
		gmii_tx_pkg::byte_t pay[$];
		gmii_tx_pkg::byte_t exp_q[$];
		gmii_tx_pkg::qword_t words[$];
		gmii_tx_pkg::crc_t fcs;
		int n;
		int len;
		int takes;
		int en_cyc;
		int slot;
		bit done;
		n = byte_clocks(row_speed[r]);
		len = int'(row_len[r]);
		for (int w = 0; w < (len + 7) / 8; w++)
			words.push_back({next_random(), next_random()});
		for (int i = 0; i < len; i++)
			pay.push_back(words[i / 8][8 * (i % 8) +: 8]);	// frame byte 0 lowest
		fcs = payload_crc(pay);
		repeat (gmii_tx_pkg::PREAMBLE_LEN) exp_q.push_back(gmii_tx_pkg::PREAMBLE_BYTE);
		exp_q.push_back(gmii_tx_pkg::SFD_BYTE);
		foreach (pay[i])
			exp_q.push_back(pay[i]);
		for (int k = 0; k < 4; k++)
			exp_q.push_back(fcs[8 * k +: 8]);	// check bytes lowest first
		while (cts !== 1'b1)
			@(posedge clk125);
		@(negedge clk125);
		rbytes = row_len[r];
		rdata = words[0];
		rts = 1'b1;
		takes = 0;
		en_cyc = 0;
		done = 1'b0;
		while (!done)
		begin
			@(posedge clk125);
			if (word_take)
				takes++;
			if (gmii_tx_en)
			begin
				slot = en_cyc / n;	// byte slot of this clock
				if (slot < exp_q.size())
					check_byte(gmii_txd, exp_q[slot],
						$sformatf("frame byte %0d clock %0d of its slot", slot, en_cyc % n));
				en_cyc++;
			end
			else if (en_cyc > 0)
				done = 1'b1;
			@(negedge clk125);
			if (takes > 0)
				rts = 1'b0;
			rdata = (takes < words.size()) ? words[takes] : '0;
		end
		while (cts !== 1'b1)
			@(posedge clk125);	// gap over
		if (en_cyc % n != 0)
			note_failure("tx_en length is not a whole number of byte times");
		check_len(gmii_tx_pkg::len_t'(en_cyc / n), row_len[r] + gmii_tx_pkg::PREAMBLE_LEN + 16'd1 +
			gmii_tx_pkg::FCS_LEN, "tx_en byte times");
		check_len(gmii_tx_pkg::len_t'(takes), gmii_tx_pkg::len_t'(words.size()), "word_take count");
		exp_pkts = exp_pkts + 32'd1;
		exp_bytes = exp_bytes + gmii_tx_pkg::stat_t'(row_len[r]);
		check_stat(tx_pkt_cnt, exp_pkts, "tx_pkt_cnt");
		check_stat(tx_byte_cnt, exp_bytes, "tx_byte_cnt");
	endtask

	// rts offered with the link down must not start a frame
	task automatic dead_link(input int r);
		bit cts_seen;
		bit en_seen;
		cts_seen = 1'b0;
		en_seen = 1'b0;
		linkup = 1'b0;
		repeat (2) @(negedge clk125);
		rbytes = row_len[r];
		rts = 1'b1;
		repeat (300)
		begin
			@(posedge clk125);
			cts_seen |= cts;
			en_seen |= gmii_tx_en;
		end
		@(negedge clk125);
		rts = 1'b0;
		if (cts_seen)
			note_failure("cts rose while linkup was low");
		if (en_seen)
			note_failure("gmii_tx_en rose while linkup was low");
		check_stat(tx_pkt_cnt, exp_pkts, "tx_pkt_cnt with link down");
		check_stat(tx_byte_cnt, exp_bytes, "tx_byte_cnt with link down");
	endtask

	task automatic clear_byte_count();
		check_stat(tx_pkt_cnt, exp_pkts, "tx_pkt_cnt before clear");
		check_stat(tx_byte_cnt, exp_bytes, "tx_byte_cnt before clear");
		@(negedge clk125);
		tx_byte_cnt_clr = 1'b1;
		@(negedge clk125);
		tx_byte_cnt_clr = 1'b0;
		@(posedge clk125);
		check_stat(tx_byte_cnt, '0, "tx_byte_cnt after clear");
		check_stat(tx_pkt_cnt, exp_pkts, "tx_pkt_cnt after clear");
		exp_bytes = '0;
	endtask

	// cycle budget from the table covering every frame and gap with slack
	initial
	begin
		int limit;
		int cycles;
		gmii_tx_pkg::tx_state_t st;
		limit = 200;
		cycles = 0;
		for (int r = 0; r < NROWS; r++)
			limit += (12 + int'(row_len[r]) + int'(gmii_tx_pkg::GAP_LEN) + 2) *
				byte_clocks(row_speed[r]);
		while (cycles < limit)
		begin
			@(posedge clk125);
			cycles++;
		end
		st = gmii_tx_i.gmii_tx_fsm_i.state;
		$display("timeout after %0d cycles, sequencer stuck in %s", cycles, st.name());
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		int err_start;
		rst_ = 1'b0;
		fmac_speed = gmii_tx_pkg::SPEED_1G;
		linkup = 1'b1;
		rts = 1'b0;
		rdata = '0;
		rbytes = '0;
		tx_byte_cnt_clr = 1'b0;
		repeat (4) @(posedge clk125);
		@(negedge clk125);
		rst_ = 1'b1;
		err_start = errors;
		repeat (2) @(posedge clk125);	// cts registered one cycle after release
		if (gmii_tx_en !== 1'b0)
			note_failure("gmii_tx_en is not low after reset");
		if (cts !== 1'b1)
			note_failure("cts is not high after reset with linkup high");
		check_stat(tx_pkt_cnt, '0, "tx_pkt_cnt after reset");
		check_stat(tx_byte_cnt, '0, "tx_byte_cnt after reset");
		finish_test("reset", err_start);
		for (int r = 0; r < NROWS; r++)
		begin
			err_start = errors;
			@(negedge clk125);
			fmac_speed = row_speed[r];
			if (!row_link[r])
				dead_link(r);
			else
			begin
				linkup = 1'b1;
				if (row_clr[r])
					clear_byte_count();
				send_frame(r);
			end
			finish_test($sformatf("row %0d %s len %0d link %0d clr %0d", r, row_speed[r].name(),
				row_len[r], row_link[r], row_clr[r]), err_start);
		end
		$display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
gmii_tx_pkg.sv
byte_strobe_timer.sv
gmii_tx_fsm.sv
tx_byte_path.sv
fcs_crc32.sv
tx_stat_counters.sv
gmii_tx.sv
tb_gmii_tx.sv

// ==== Makefile ====
# Verilator lint and simulation of the GMII transmit framer

VERILATOR = verilator
VFLAGS    = --timing
TB_TOP    = tb_gmii_tx
RTL_TOP   = gmii_tx
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
